/* rtl/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // Cache geometry
    localparam int NUM_WAYS    = 4;
    localparam int LINE_BITS   = 256;
    localparam int WORD_BITS   = 32;
    localparam int OFFSET_BITS = 5;

    // Upper address bits naming one line, also used as the full tag
    typedef logic [31-OFFSET_BITS:0] line_addr_t;

    typedef logic [1:0] way_idx_t;

    typedef enum logic [2:0] {
        idle_s,
        compare_tag_s,
        allocate_s,
        prefetch_s,
        prefetch_fill_s
    } icache_state_t;

    // One way as seen at the lookup set
    typedef struct packed {
        logic       valid;
        line_addr_t tag;
    } way_status_t;

    // Fill command to one way
    typedef struct packed {
        logic                 we;
        line_addr_t           tag;
        logic [LINE_BITS-1:0] line;
    } way_write_t;

    // Line and word the controller is looking at
    typedef struct packed {
        line_addr_t line;
        logic [2:0] word;
    } lookup_t;

endpackage

`default_nettype wire

/* rtl/icache_way.sv */
`default_nettype none

module icache_way
    import icache_pkg::*;
#(
    parameter int SETS = 16
) (
    input  wire logic           clk,
    input  wire logic           arst_n,
    input  wire lookup_t        lookup,
    input  wire way_write_t     wr,
    output way_status_t         status,
    output logic [LINE_BITS-1:0] line
);

    localparam int SET_BITS = $clog2(SETS);

    logic                 valid_q  [SETS];
    line_addr_t           tag_mem  [SETS];
    logic [LINE_BITS-1:0] line_mem [SETS];
    logic [SET_BITS-1:0]  set_idx;

    // Set comes from the low bits of the line address
    assign set_idx = lookup.line[SET_BITS-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= 1'b0;
            end
        end else if (wr.we) begin
            valid_q[set_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we) begin
            tag_mem[set_idx]  <= wr.tag;
            line_mem[set_idx] <= wr.line;
        end
    end

    // Combinational read at the lookup set
    assign status.valid = valid_q[set_idx];
    assign status.tag   = tag_mem[set_idx];
    assign line         = line_mem[set_idx];

    // Fill tag comes from the controller, set from the lookup; they must agree
    fill_set_match: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr.we |-> (wr.tag[SET_BITS-1:0] == set_idx)
    );

endmodule

`default_nettype wire

/* rtl/icache_plru.sv */
`default_nettype none

module icache_plru
    import icache_pkg::*;
#(
    parameter int SETS = 16
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic [$clog2(SETS)-1:0]  set_index,
    input  wire logic [NUM_WAYS-1:0]      valid,
    input  wire logic                     touch,
    input  wire way_idx_t                 touch_way,
    output way_idx_t                      victim_way
);

    // bit0 picks the half, bit1 picks in ways 0-1, bit2 picks in ways 2-3
    logic [2:0] tree_q [SETS];
    logic [2:0] tree;
    logic [2:0] tree_next;

    assign tree = tree_q[set_index];

    always_comb begin
        victim_way = '0;
        if (!(&valid)) begin
            // Lowest invalid way wins, so scan downward
            for (int i = NUM_WAYS - 1; i >= 0; i--) begin
                if (!valid[i]) begin
                    victim_way = way_idx_t'(i);
                end
            end
        end else if (!tree[0]) begin
            victim_way = tree[1] ? way_idx_t'(1) : way_idx_t'(0);
        end else begin
            victim_way = tree[2] ? way_idx_t'(3) : way_idx_t'(2);
        end
    end

    // Point every bit on the touched path away from the touched way
    always_comb begin
        tree_next    = tree;
        tree_next[0] = ~touch_way[1];
        if (touch_way[1]) begin
            tree_next[2] = ~touch_way[0];
        end else begin
            tree_next[1] = ~touch_way[0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            tree_q[set_index] <= tree_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/icache_hit_select.sv */
`default_nettype none

module icache_hit_select
    import icache_pkg::*;
(
    input  wire lookup_t              lookup,
    input  wire way_status_t          status [NUM_WAYS],
    input  wire logic [LINE_BITS-1:0] lines  [NUM_WAYS],
    output logic                      hit,
    output way_idx_t                  hit_way,
    output logic [WORD_BITS-1:0]      rdata
);

    logic [NUM_WAYS-1:0] match;

    // Full line address is stored, so a plain equality suffices
    always_comb begin
        for (int i = 0; i < NUM_WAYS; i++) begin
            match[i] = status[i].valid && (status[i].tag == lookup.line);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (match[i]) begin
                hit_way = way_idx_t'(i);
            end
        end
    end

    assign hit = |match;

    // Word select within the hit line
    assign rdata = lines[hit_way][lookup.word*WORD_BITS +: WORD_BITS];

    // A line may live in one way only; a duplicate means a fill went wrong
    always_comb begin
        single_match: assert final ($isunknown(match) || $onehot0(match));
    end

endmodule

`default_nettype wire

/* rtl/icache_control.sv */
`default_nettype none

module icache_control
    import icache_pkg::*;
#(
    parameter int SETS = 16
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    // CPU side
    input  wire logic                 cpu_read,
    input  wire logic [31:0]          cpu_addr,
    output logic                      cpu_resp,
    // From the hit selector and PLRU
    input  wire logic                 hit,
    input  wire way_idx_t             hit_way,
    input  wire way_idx_t             victim_way,
    // Memory side
    output logic                      mem_read,
    output line_addr_t                mem_addr,
    input  wire logic                 mem_resp,
    input  wire logic [LINE_BITS-1:0] mem_rdata,
    // To the ways and PLRU
    output lookup_t                   lookup,
    output way_write_t                wr [NUM_WAYS],
    output logic                      touch,
    output way_idx_t                  touch_way
);

    icache_state_t state_q;
    icache_state_t state_d;
    logic          demand_miss_q;
    logic          demand_miss_d;
    line_addr_t    req_line_q;
    logic [2:0]    req_word_q;
    logic          prefetching;
    logic          fill;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q       <= idle_s;
            demand_miss_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            demand_miss_q <= demand_miss_d;
        end
    end

    // Request address, captured at acceptance
    always_ff @(posedge clk) begin
        if (state_q == idle_s && cpu_read) begin
            req_line_q <= cpu_addr[31:OFFSET_BITS];
            req_word_q <= cpu_addr[OFFSET_BITS-1:2];
        end
    end

    // Lookup follows the next line while prefetching
    assign prefetching = (state_q == prefetch_s) || (state_q == prefetch_fill_s);

    always_comb begin
        if (prefetching) begin
            lookup.line = req_line_q + line_addr_t'(1);
            lookup.word = '0;
        end else begin
            lookup.line = req_line_q;
            lookup.word = req_word_q;
        end
    end

    always_comb begin
        state_d       = state_q;
        demand_miss_d = demand_miss_q;
        cpu_resp      = 1'b0;
        touch         = 1'b0;
        touch_way     = hit_way;
        fill          = 1'b0;
        case (state_q)
            idle_s: begin
                if (cpu_read) begin
                    state_d = compare_tag_s;
                end
            end
            compare_tag_s: begin
                if (hit) begin
                    cpu_resp      = 1'b1;
                    touch         = 1'b1;
                    demand_miss_d = 1'b0;
                    // Only a response that followed a fill goes on to prefetch
                    state_d       = demand_miss_q ? prefetch_s : idle_s;
                end else begin
                    state_d = allocate_s;
                end
            end
            allocate_s: begin
                if (mem_resp) begin
                    fill          = 1'b1;
                    touch         = 1'b1;
                    touch_way     = victim_way;
                    demand_miss_d = 1'b1;
                    state_d       = compare_tag_s;
                end
            end
            prefetch_s: begin
                state_d = hit ? idle_s : prefetch_fill_s;
            end
            prefetch_fill_s: begin
                if (mem_resp) begin
                    fill      = 1'b1;
                    touch     = 1'b1;
                    touch_way = victim_way;
                    state_d   = idle_s;
                end
            end
            default: begin
                state_d = idle_s;
            end
        endcase
    end

    // Memory request stays up for the whole fill state
    assign mem_read = (state_q == allocate_s) || (state_q == prefetch_fill_s);
    assign mem_addr = lookup.line;

    // Fill goes only to the victim way
    always_comb begin
        for (int i = 0; i < NUM_WAYS; i++) begin
            wr[i].we   = fill && (victim_way == way_idx_t'(i));
            wr[i].tag  = lookup.line;
            wr[i].line = mem_rdata;
        end
    end

    no_mem_read_in_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state_q == idle_s) |-> !mem_read
    );

    resp_only_in_compare: assert property (
        @(posedge clk) disable iff (!arst_n)
        cpu_resp |-> (state_q == compare_tag_s)
    );

    // Fill target must not move while memory is busy
    fill_victim_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_read && !mem_resp) |=> $stable(victim_way)
    );

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int SETS = 16
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    // CPU port
    input  wire logic                 cpu_read,
    input  wire logic [31:0]          cpu_addr,
    output logic                      cpu_resp,
    output logic [WORD_BITS-1:0]      cpu_rdata,
    // Memory port
    output logic                      mem_read,
    output line_addr_t                mem_addr,
    input  wire logic                 mem_resp,
    input  wire logic [LINE_BITS-1:0] mem_rdata
);

    localparam int SET_BITS = $clog2(SETS);

    lookup_t              lookup;
    way_write_t           wr     [NUM_WAYS];
    way_status_t          status [NUM_WAYS];
    logic [LINE_BITS-1:0] lines  [NUM_WAYS];
    logic [NUM_WAYS-1:0]  way_valid;
    logic                 hit;
    way_idx_t             hit_way;
    way_idx_t             victim_way;
    logic                 touch;
    way_idx_t             touch_way;

    icache_control #(
        .SETS(SETS)
    ) u_control (
        .clk        (clk),
        .arst_n     (arst_n),
        .cpu_read   (cpu_read),
        .cpu_addr   (cpu_addr),
        .cpu_resp   (cpu_resp),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .mem_read   (mem_read),
        .mem_addr   (mem_addr),
        .mem_resp   (mem_resp),
        .mem_rdata  (mem_rdata),
        .lookup     (lookup),
        .wr         (wr),
        .touch      (touch),
        .touch_way  (touch_way)
    );

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        icache_way #(
            .SETS(SETS)
        ) u_way (
            .clk    (clk),
            .arst_n (arst_n),
            .lookup (lookup),
            .wr     (wr[g]),
            .status (status[g]),
            .line   (lines[g])
        );

        assign way_valid[g] = status[g].valid;
    end

    icache_hit_select u_hit_select (
        .lookup  (lookup),
        .status  (status),
        .lines   (lines),
        .hit     (hit),
        .hit_way (hit_way),
        .rdata   (cpu_rdata)
    );

    icache_plru #(
        .SETS(SETS)
    ) u_plru (
        .clk        (clk),
        .arst_n     (arst_n),
        .set_index  (lookup.line[SET_BITS-1:0]),
        .valid      (way_valid),
        .touch      (touch),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

endmodule

`default_nettype wire

/* testbench/icache_mem_model.sv */
`default_nettype none

module icache_mem_model
    import icache_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            arst_n,
    input  wire logic            mem_read,
    input  wire line_addr_t      mem_addr,
    output logic                 mem_resp,
    output logic [LINE_BITS-1:0] mem_rdata,
    output int                   served
);

    integer     seed = 20;
    logic       read_seen;
    line_addr_t addr_seen;
    logic       busy;
    int         delay;

    initial begin
        mem_resp  = 1'b0;
        mem_rdata = '0;
    end

    // Request sampled mid-cycle, away from the edge where it changes
    always @(negedge clk) begin
        read_seen <= mem_read;
        addr_seen <= mem_addr;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_resp <= 1'b0;
            busy     <= 1'b0;
            served   <= 0;
        end else if (mem_resp) begin
            mem_resp <= 1'b0;
            busy     <= 1'b0;
        end else if (read_seen && !busy) begin
            busy   <= 1'b1;
            delay  <= 1 + ($unsigned($random(seed)) % 6);
            served <= served + 1;
        end else if (busy) begin
            if (delay == 1) begin
                mem_resp <= 1'b1;
                // Word k holds its own byte address, scrambled
                for (int k = 0; k < 8; k++) begin
                    mem_rdata[k*32 +: 32] <= ({addr_seen, 5'b0} + 32'(4 * k)) ^ 32'hA5A5_0000;
                end
            end
            delay <= delay - 1;
        end
    end

endmodule

`default_nettype wire

/* testbench/icache_tb.sv */
`default_nettype none

module icache_tb
    import icache_pkg::*;
();

    localparam int SETS     = 16;
    localparam int SET_BITS = $clog2(SETS);
    localparam int TIMEOUT  = 50;

    logic                 clk;
    logic                 arst_n;
    logic                 cpu_read;
    logic [31:0]          cpu_addr;
    logic                 cpu_resp;
    logic [WORD_BITS-1:0] cpu_rdata;
    logic                 mem_read;
    line_addr_t           mem_addr;
    logic                 mem_resp;
    logic [LINE_BITS-1:0] mem_rdata;
    int                   served;

    integer seed = 20;
    int     errors;
    int     checks;
    int     tests;
    int     test_base;
    int     expected_reqs;
    logic   aborted;

    // Reference cache contents and tree bits
    logic       ref_valid [SETS][NUM_WAYS];
    line_addr_t ref_tag   [SETS][NUM_WAYS];
    logic [2:0] ref_tree  [SETS];

    icache_top #(
        .SETS(SETS)
    ) uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_read  (cpu_read),
        .cpu_addr  (cpu_addr),
        .cpu_resp  (cpu_resp),
        .cpu_rdata (cpu_rdata),
        .mem_read  (mem_read),
        .mem_addr  (mem_addr),
        .mem_resp  (mem_resp),
        .mem_rdata (mem_rdata)
    );

    icache_mem_model u_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_read  (mem_read),
        .mem_addr  (mem_addr),
        .mem_resp  (mem_resp),
        .mem_rdata (mem_rdata),
        .served    (served)
    );

    always #10 clk = ~clk;

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(string what);
        errors++;
        aborted = 1'b1;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %s: %0d mismatches", name, errors - test_base);
        test_base = errors;
    endtask

    function automatic int set_of(line_addr_t line);
        return int'(line[SET_BITS-1:0]);
    endfunction

    function automatic int find_line(line_addr_t line);
        int s;
        s = set_of(line);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == line) begin
                return w;
            end
        end
        return -1;
    endfunction

    // Lowest empty way first, then follow the tree
    function automatic int pick_victim(int s);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!ref_valid[s][w]) begin
                return w;
            end
        end
        if (ref_tree[s][0] == 1'b0) begin
            return ref_tree[s][1] ? 1 : 0;
        end
        return ref_tree[s][2] ? 3 : 2;
    endfunction

    // Bits on the path of w now point at the other side
    task automatic touch_tree(int s, int w);
        ref_tree[s][0] = (w < 2);
        if (w < 2) begin
            ref_tree[s][1] = (w == 0);
        end else begin
            ref_tree[s][2] = (w == 2);
        end
    endtask

    task automatic fill_line(line_addr_t line);
        int s;
        int w;
        s = set_of(line);
        w = pick_victim(s);
        ref_valid[s][w] = 1'b1;
        ref_tag[s][w]   = line;
        touch_tree(s, w);
        expected_reqs++;
    endtask

    task automatic clear_model();
        for (int s = 0; s < SETS; s++) begin
            ref_tree[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
        expected_reqs = 0;
    endtask

    // After a miss the next line is fetched unless already held
    task automatic expect_prefetch(string name, line_addr_t next_line);
        logic wanted;
        int   cycles;
        wanted = (find_line(next_line) < 0);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!mem_read && cycles < 3);
        check_value({name, " prefetch"}, wanted, mem_read);
        if (mem_read) begin
            check_value({name, " prefetch addr"}, next_line, mem_addr);
            cycles = 0;
            while (mem_read && cycles < TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (mem_read) begin
                report_timeout({"prefetch mem_resp after ", name});
            end else if (wanted) begin
                fill_line(next_line);
            end
        end
    endtask

    task automatic do_read(string name, logic [31:0] addr);
        line_addr_t line;
        int         way;
        int         cycles;
        logic       fetched;
        if (aborted) begin
            return;
        end
        line    = addr[31:OFFSET_BITS];
        way     = find_line(line);
        cycles  = 0;
        fetched = 1'b0;
        @(posedge clk);
        cpu_read <= 1'b1;
        cpu_addr <= addr;
        do begin
            @(negedge clk);
            cycles++;
            if (mem_read && !fetched) begin
                fetched = 1'b1;
                check_value({name, " miss addr"}, line, mem_addr);
            end
        end while (!cpu_resp && cycles < TIMEOUT);
        if (!cpu_resp) begin
            report_timeout({"cpu_resp on ", name});
            return;
        end
        check_value({name, " hit"}, (way >= 0), !fetched);
        // Aligned address equals line*32 + 4*word
        check_value({name, " data"}, addr ^ 32'hA5A5_0000, cpu_rdata);
        if (way >= 0) begin
            check_value({name, " hit latency"}, 2, cycles);
            touch_tree(set_of(line), way);
        end else begin
            fill_line(line);
        end
        @(posedge clk);
        cpu_read <= 1'b0;
        if (way < 0) begin
            expect_prefetch(name, line + 1'b1);
        end
    endtask

    initial begin
        line_addr_t rline;
        logic [2:0] rword;
        int         wait_cycles;
        clk       = 1'b0;
        arst_n    = 1'b0;
        cpu_read  = 1'b0;
        cpu_addr  = '0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        test_base = 0;
        aborted   = 1'b0;
        clear_model();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        do_read("cold miss", 32'h0000_1024);
        do_read("warm hit", 32'h0000_1028);
        end_test("cold_miss_hit");

        // Line 0x82 came in by prefetch; 0x103 is held before 0x102 misses
        do_read("prefetched line", 32'h0000_1040);
        do_read("line ahead", 32'h0000_2060);
        do_read("line behind", 32'h0000_2040);
        end_test("next_line_prefetch");

        for (int k = 0; k < 8; k++) begin
            do_read("word select", 32'h0000_1040 + 32'(4 * k));
        end
        end_test("word_select");

        // Five lines in set 10, one revisit, then sweep to expose the victim
        for (int t = 1; t <= 4; t++) begin
            do_read("plru fill", 32'(t * 16 + 10) << 5);
        end
        do_read("plru revisit", 32'(16 + 10) << 5);
        do_read("plru evict", 32'(5 * 16 + 10) << 5);
        for (int t = 1; t <= 5; t++) begin
            do_read("plru sweep", 32'(t * 16 + 10) << 5);
        end
        end_test("plru_replacement");

        for (int i = 0; i < 300; i++) begin
            rline = line_addr_t'(16 * (1 + $unsigned($random(seed)) % 6));
            rline = rline + line_addr_t'(4 + $unsigned($random(seed)) % 4);
            rword = 3'($unsigned($random(seed)) % 8);
            do_read("random", {rline, rword, 2'b00});
        end
        check_value("request count", expected_reqs, served);
        end_test("random_mix");

        // Second reset lands while a demand miss waits on memory
        @(posedge clk);
        cpu_read <= 1'b1;
        cpu_addr <= 32'h0000_3000;
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!mem_read && wait_cycles < TIMEOUT);
        if (!mem_read) begin
            report_timeout("mem_read before the second reset");
        end
        @(posedge clk);
        arst_n   <= 1'b0;
        cpu_read <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            check_value("reset cpu_resp", 0, cpu_resp);
            check_value("reset mem_read", 0, mem_read);
        end
        @(posedge clk);
        arst_n <= 1'b1;
        clear_model();
        do_read("after reset", 32'h0000_1024);
        do_read("after reset", 32'h0000_0340);
        do_read("after reset", 32'h0000_2060);
        end_test("reset_state");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/icache_pkg.sv
rtl/icache_way.sv
rtl/icache_plru.sv
rtl/icache_hit_select.sv
rtl/icache_control.sv
rtl/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv
